// ==== Bender.yml ====
package:
  name: mem_top

sources:
  - hw/mem_pkg.sv
  - hw/bus_control.sv
  - hw/work_ram.sv
  - hw/palette_ram.sv
  - hw/io_regs.sv
  - hw/sound_fifo.sv
  - hw/mem_top.sv
  - target: test
    files:
      - test/tb_mem_top.sv

// ==== hw/bus_control.sv ====
`timescale 1ns/100ps

module bus_control (
    input  logic              clock,
    input  logic              reset,
    input  mem_pkg::bus_addr_t bus_addr,
    input  mem_pkg::mem_size_t bus_size,
    input  logic              bus_write,
    input  mem_pkg::word_t    bus_wdata,
    input  mem_pkg::word_t    work_ram_rdata,
    input  mem_pkg::word_t    palette_rdata,
    input  mem_pkg::word_t    io_rdata,
    output logic              bus_pause,
    output mem_pkg::word_t    bus_rdata,
    output mem_pkg::mem_port_t work_ram_port,
    output mem_pkg::mem_port_t palette_port,
    output mem_pkg::mem_port_t io_port
);

    mem_pkg::bus_addr_t addr_lat;
    mem_pkg::mem_size_t size_lat;
    logic               write_lat;
    mem_pkg::bus_addr_t mem_addr;
    logic [7:0]         lat_region;
    logic [3:0]         lanes;

    // Write data arrives one cycle after the address, so every write
    // is latched and the master is held for that one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr_lat  <= '0;
            size_lat  <= mem_pkg::SIZE_BYTE;
            write_lat <= 1'b0;
        end else begin
            addr_lat  <= bus_addr;
            size_lat  <= bus_size;
            write_lat <= bus_write & ~bus_pause;
        end
    end

    assign bus_pause  = write_lat;
    assign lat_region = addr_lat.split.region;

    // Latched address while the write completes, live address for reads
    assign mem_addr = write_lat ? addr_lat : bus_addr;

    // Byte lane enables, little endian
    always_comb begin
        lanes = 4'b0000;
        if (write_lat) begin
            case (size_lat)
                mem_pkg::SIZE_BYTE: lanes[addr_lat.raw[1:0]] = 1'b1;
                mem_pkg::SIZE_HALF: lanes = addr_lat.raw[1] ? 4'b1100 : 4'b0011;
                mem_pkg::SIZE_WORD: lanes = 4'b1111;
                default:            lanes = 4'b0000;
            endcase
        end
    end

    assign work_ram_port = '{
        addr:    mem_addr,
        byte_en: (lat_region == mem_pkg::REGION_WORK_RAM) ? lanes : 4'b0000,
        wdata:   bus_wdata
    };

    assign palette_port = '{
        addr:    mem_addr,
        byte_en: (lat_region == mem_pkg::REGION_PALETTE) ? lanes : 4'b0000,
        wdata:   bus_wdata
    };

    assign io_port = '{
        addr:    mem_addr,
        byte_en: (lat_region == mem_pkg::REGION_IO) ? lanes : 4'b0000,
        wdata:   bus_wdata
    };

    // Unmapped space reads as zero
    always_comb begin
        case (lat_region)
            mem_pkg::REGION_WORK_RAM: bus_rdata = work_ram_rdata;
            mem_pkg::REGION_PALETTE:  bus_rdata = palette_rdata;
            mem_pkg::REGION_IO:       bus_rdata = io_rdata;
            default:                  bus_rdata = '0;
        endcase
    end

endmodule

// ==== hw/io_regs.sv ====
`timescale 1ns/100ps

module io_regs #(
    parameter int NUM_IO_REGS = 192
) (
    input  logic               clock,
    input  logic               reset,
    input  mem_pkg::mem_port_t port,
    input  logic [15:0]        buttons,
    input  logic [15:0]        reg_if,
    input  mem_pkg::word_t     fifo_head,
    output mem_pkg::word_t     rdata,
    output logic [15:0]        int_acks,
    output logic [15:0]        ie,
    output logic               fifo_push
);

    localparam int IDX_W = $clog2(NUM_IO_REGS);

    mem_pkg::word_t   regs [NUM_IO_REGS];
    logic [21:0]      word_idx;
    logic [IDX_W-1:0] widx;
    logic             in_range;
    logic             hit_key;
    logic             hit_if;
    logic             hit_fifo;
    logic [3:0]       wr_lanes;
    logic [15:0]      ack_next;
    mem_pkg::word_t   rd_word;

    assign word_idx = port.addr.split.offset[23:2];
    assign widx     = word_idx[IDX_W-1:0];
    assign in_range = word_idx < NUM_IO_REGS;
    assign hit_key  = in_range && (word_idx == mem_pkg::KEYINPUT_IDX);
    assign hit_if   = in_range && (word_idx == mem_pkg::IF_IDX);
    assign hit_fifo = in_range && (word_idx == mem_pkg::FIFO_A_IDX);

    // Lanes that land in plain storage
    always_comb begin
        wr_lanes = in_range ? port.byte_en : 4'b0000;
        if (hit_key) begin
            wr_lanes[1:0] = 2'b00;
        end else if (hit_if) begin
            wr_lanes[3:2] = 2'b00;
        end else if (hit_fifo) begin
            wr_lanes = 4'b0000;
        end
    end

    // Upper half of IF acknowledges, so it only lives for one cycle
    assign ack_next[7:0]  = (hit_if && port.byte_en[2]) ? port.wdata[23:16] : 8'h00;
    assign ack_next[15:8] = (hit_if && port.byte_en[3]) ? port.wdata[31:24] : 8'h00;

    assign fifo_push = hit_fifo & port.byte_en[0];
    assign ie        = regs[mem_pkg::IF_IDX][15:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                regs[i] <= '0;
            end
            int_acks <= '0;
        end else begin
            int_acks <= ack_next;
            for (int b = 0; b < 4; b++) begin
                if (wr_lanes[b]) begin
                    regs[widx][8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (hit_key) begin
            rd_word = {regs[widx][31:16], buttons};
        end else if (hit_if) begin
            rd_word = {reg_if, regs[widx][15:0]};
        end else if (hit_fifo) begin
            rd_word = fifo_head;
        end else if (in_range) begin
            rd_word = regs[widx];
        end
    end

    always_ff @(posedge clock) begin
        rdata <= rd_word;
    end

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0] word_t;

    // Bus address, seen either as a flat word or as region and offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0]  region;
            logic [23:0] offset;
        } split;
    } bus_addr_t;

    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // Request from the bus controller to one datapath block
    typedef struct packed {
        bus_addr_t  addr;
        logic [3:0] byte_en;
        word_t      wdata;
    } mem_port_t;

    // Top address byte of each region
    localparam logic [7:0] REGION_WORK_RAM = 8'h03;
    localparam logic [7:0] REGION_IO       = 8'h04;
    localparam logic [7:0] REGION_PALETTE  = 8'h05;

    localparam logic [9:0] PALETTE_OBJ_OFFSET = 10'h200;

    // Word indices inside the I/O block
    localparam int KEYINPUT_IDX = 12;
    localparam int IF_IDX       = 128;
    localparam int FIFO_A_IDX   = 40;

endpackage

// ==== hw/mem_top.sv ====
`timescale 1ns/100ps

module mem_top #(
    parameter int WORK_RAM_WORDS = 8192,
    parameter int PALETTE_WORDS  = 128,
    parameter int NUM_IO_REGS    = 192,
    parameter int FIFO_DEPTH     = 8
) (
    input  logic                             clock,
    input  logic                             reset,
    // CPU bus
    input  mem_pkg::bus_addr_t               bus_addr,
    input  mem_pkg::mem_size_t               bus_size,
    input  logic                             bus_write,
    input  mem_pkg::word_t                   bus_wdata,
    output mem_pkg::word_t                   bus_rdata,
    output logic                             bus_pause,
    // Graphics palette reads
    input  logic [$clog2(PALETTE_WORDS)-1:0] pal_bg_addr,
    input  logic [$clog2(PALETTE_WORDS)-1:0] pal_obj_addr,
    output mem_pkg::word_t                   pal_bg_data,
    output mem_pkg::word_t                   pal_obj_data,
    // Keys and interrupts
    input  logic [15:0]                      buttons,
    input  logic [15:0]                      reg_if,
    output logic [15:0]                      int_acks,
    output logic [15:0]                      ie,
    // Sound side of the sample FIFO
    input  logic                             fifo_pop,
    input  logic                             fifo_clr,
    output mem_pkg::word_t                   fifo_sample,
    output logic [3:0]                       fifo_level
);

    mem_pkg::mem_port_t work_ram_port, palette_port, io_port;
    mem_pkg::word_t     work_ram_rdata, palette_rdata, io_rdata;
    logic               fifo_push;

    bus_control u_bus_control (
        .clock, .reset, .bus_addr, .bus_size, .bus_write, .bus_wdata,
        .work_ram_rdata, .palette_rdata, .io_rdata,
        .bus_pause, .bus_rdata, .work_ram_port, .palette_port, .io_port
    );

    work_ram #(.WORK_RAM_WORDS(WORK_RAM_WORDS)) u_work_ram (
        .clock, .port(work_ram_port), .rdata(work_ram_rdata)
    );

    palette_ram #(.PALETTE_WORDS(PALETTE_WORDS)) u_palette_ram (
        .clock, .port(palette_port), .bg_addr(pal_bg_addr), .obj_addr(pal_obj_addr),
        .rdata(palette_rdata), .bg_data(pal_bg_data), .obj_data(pal_obj_data)
    );

    io_regs #(.NUM_IO_REGS(NUM_IO_REGS)) u_io_regs (
        .clock, .reset, .port(io_port), .buttons, .reg_if, .fifo_head(fifo_sample),
        .rdata(io_rdata), .int_acks, .ie, .fifo_push
    );

    sound_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_sound_fifo (
        .clock, .reset, .push(fifo_push), .pop(fifo_pop), .clr(fifo_clr),
        .push_data(bus_wdata), .head(fifo_sample), .level(fifo_level)
    );

endmodule

// ==== hw/palette_ram.sv ====
`timescale 1ns/100ps

module palette_ram #(
    parameter int PALETTE_WORDS = 128
) (
    input  logic                             clock,
    input  mem_pkg::mem_port_t               port,
    input  logic [$clog2(PALETTE_WORDS)-1:0] bg_addr,
    input  logic [$clog2(PALETTE_WORDS)-1:0] obj_addr,
    output mem_pkg::word_t                   rdata,
    output mem_pkg::word_t                   bg_data,
    output mem_pkg::word_t                   obj_data
);

    localparam int IDX_W = $clog2(PALETTE_WORDS);

    // Bank 0 holds background colors, bank 1 object colors
    mem_pkg::word_t   banks [2][PALETTE_WORDS];
    mem_pkg::word_t   bank_q [2];
    logic [9:0]       pal_off;
    logic             is_obj;
    logic             obj_sel;
    logic [IDX_W-1:0] idx;

    initial begin
        for (int i = 0; i < PALETTE_WORDS; i++) begin
            banks[0][i] = '0;
            banks[1][i] = '0;
        end
    end

    assign pal_off = port.addr.split.offset[9:0];
    assign is_obj  = pal_off >= mem_pkg::PALETTE_OBJ_OFFSET;
    // Removing the 0x200 bank start leaves the word index bits as they are
    assign idx     = pal_off[IDX_W+1:2];

    always_ff @(posedge clock) begin
        for (int b = 0; b < 4; b++) begin
            if (port.byte_en[b]) begin
                banks[is_obj][idx][8*b +: 8] <= port.wdata[8*b +: 8];
            end
        end
        bank_q[0] <= banks[0][idx];
        bank_q[1] <= banks[1][idx];
        obj_sel   <= is_obj;
        // Graphics side is read only
        bg_data   <= banks[0][bg_addr];
        obj_data  <= banks[1][obj_addr];
    end

    assign rdata = bank_q[obj_sel];

endmodule

// ==== hw/sound_fifo.sv ====
`timescale 1ns/100ps

module sound_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           push,
    input  logic           pop,
    input  logic           clr,
    input  mem_pkg::word_t push_data,
    output mem_pkg::word_t head,
    output logic [3:0]     level
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    mem_pkg::word_t   samples [FIFO_DEPTH];
    logic [PTR_W-1:0] get_ptr;
    logic [PTR_W-1:0] put_ptr;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    initial begin
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            samples[i] = '0;
        end
    end

    // Strobes against a full or empty buffer are dropped
    assign do_push = push & (level != 4'(FIFO_DEPTH));
    assign do_pop  = pop & (level != 4'd0);
    assign head    = samples[get_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            get_ptr <= '0;
            put_ptr <= '0;
            level   <= '0;
        end else if (clr) begin
            get_ptr <= '0;
            put_ptr <= '0;
            level   <= '0;
        end else begin
            if (do_push) begin
                put_ptr <= next_ptr(put_ptr);
            end
            if (do_pop) begin
                get_ptr <= next_ptr(get_ptr);
            end
            level <= level + {3'b000, do_push} - {3'b000, do_pop};
        end
    end

    always_ff @(posedge clock) begin
        if (do_push && !clr) begin
            samples[put_ptr] <= push_data;
        end
    end

endmodule

// ==== hw/work_ram.sv ====
`timescale 1ns/100ps

module work_ram #(
    parameter int WORK_RAM_WORDS = 8192
) (
    input  logic               clock,
    input  mem_pkg::mem_port_t port,
    output mem_pkg::word_t     rdata
);

    localparam int ADDR_W = $clog2(WORK_RAM_WORDS);

    mem_pkg::word_t    mem [WORK_RAM_WORDS];
    logic [ADDR_W-1:0] idx;

    // Power-up contents
    initial begin
        for (int i = 0; i < WORK_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Word index wraps at the array depth
    assign idx = port.addr.split.offset[ADDR_W+1:2];

    always_ff @(posedge clock) begin
        for (int b = 0; b < 4; b++) begin
            if (port.byte_en[b]) begin
                mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
            end
        end
        rdata <= mem[idx];
    end

endmodule

// ==== mem_top.f ====
hw/mem_pkg.sv
hw/bus_control.sv
hw/work_ram.sv
hw/palette_ram.sv
hw/io_regs.sv
hw/sound_fifo.sv
hw/mem_top.sv
test/tb_mem_top.sv

// ==== test/tb_mem_top.sv ====
`timescale 1ns/100ps

module tb_mem_top;

    localparam int WORK_RAM_WORDS = 64;
    localparam int PALETTE_WORDS  = 16;
    localparam int NUM_IO_REGS    = 192;
    localparam int FIFO_DEPTH     = 8;
    localparam int PAL_W          = $clog2(PALETTE_WORDS);
    localparam int NUM_OPS        = 400;
    localparam int CYCLE_LIMIT    = 4 * NUM_OPS + 100;

    logic               clock;
    logic               reset;
    mem_pkg::bus_addr_t bus_addr;
    mem_pkg::mem_size_t bus_size;
    logic               bus_write;
    mem_pkg::word_t     bus_wdata;
    mem_pkg::word_t     bus_rdata;
    logic               bus_pause;
    logic [PAL_W-1:0]   pal_bg_addr;
    logic [PAL_W-1:0]   pal_obj_addr;
    mem_pkg::word_t     pal_bg_data;
    mem_pkg::word_t     pal_obj_data;
    logic [15:0]        buttons;
    logic [15:0]        reg_if;
    logic [15:0]        int_acks;
    logic [15:0]        ie;
    logic               fifo_pop;
    logic               fifo_clr;
    mem_pkg::word_t     fifo_sample;
    logic [3:0]         fifo_level;

    // Reference model state
    mem_pkg::word_t ram_model [WORK_RAM_WORDS];
    mem_pkg::word_t pal_model [2][PALETTE_WORDS];
    mem_pkg::word_t io_model [NUM_IO_REGS];
    mem_pkg::word_t fifo_model [$];
    logic [15:0]    acks_expected;
    mem_pkg::word_t bg_expected;
    mem_pkg::word_t obj_expected;
    logic           strobes_on;
    logic [31:0]    sweep [7];

    int error_count;
    int check_count;
    int cycle_count;

    mem_top #(
        .WORK_RAM_WORDS(WORK_RAM_WORDS),
        .PALETTE_WORDS (PALETTE_WORDS),
        .NUM_IO_REGS   (NUM_IO_REGS),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) DUT (
        .clock, .reset, .bus_addr, .bus_size, .bus_write, .bus_wdata, .bus_rdata,
        .bus_pause, .pal_bg_addr, .pal_obj_addr, .pal_bg_data, .pal_obj_data,
        .buttons, .reg_if, .int_acks, .ie, .fifo_pop, .fifo_clr, .fifo_sample,
        .fifo_level
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation failed");
        $finish;
    end

    // Lanes touched by one write, little endian
    function automatic logic [3:0] lane_mask(input mem_pkg::mem_size_t size,
                                             input logic [1:0] low);
        if (size == mem_pkg::SIZE_BYTE) begin
            return 4'b0001 << low;
        end else if (size == mem_pkg::SIZE_HALF) begin
            return 4'b0011 << {low[1], 1'b0};
        end else if (size == mem_pkg::SIZE_WORD) begin
            return 4'b1111;
        end
        return 4'b0000;
    endfunction

    function automatic mem_pkg::word_t merge_lanes(input mem_pkg::word_t old,
                                                   input mem_pkg::word_t data,
                                                   input logic [3:0] lanes);
        mem_pkg::word_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Object half starts at 0x200, so the remainder is the low nine bits
    function automatic logic pal_bank(input logic [23:0] off);
        return off[9:0] >= mem_pkg::PALETTE_OBJ_OFFSET;
    endfunction

    function automatic int pal_index(input logic [23:0] off);
        return int'(off[8:2]) % PALETTE_WORDS;
    endfunction

    function automatic mem_pkg::word_t model_read(input mem_pkg::bus_addr_t addr);
        logic [23:0] off;
        int          idx;
        off = addr.split.offset;
        idx = int'(off >> 2);
        case (addr.split.region)
            mem_pkg::REGION_WORK_RAM: return ram_model[idx % WORK_RAM_WORDS];
            mem_pkg::REGION_PALETTE:  return pal_model[pal_bank(off)][pal_index(off)];
            mem_pkg::REGION_IO: begin
                if (idx == mem_pkg::KEYINPUT_IDX) begin
                    return {io_model[idx][31:16], buttons};
                end else if (idx == mem_pkg::IF_IDX) begin
                    return {reg_if, io_model[idx][15:0]};
                end else if (idx == mem_pkg::FIFO_A_IDX) begin
                    return fifo_model[0];
                end else if (idx < NUM_IO_REGS) begin
                    return io_model[idx];
                end
                return '0;
            end
            default: return '0;
        endcase
    endfunction

    function automatic mem_pkg::bus_addr_t random_addr();
        mem_pkg::bus_addr_t addr;
        logic [1:0]         low;
        logic [7:0]         region;
        low = 2'($urandom());
        case ($urandom() % 8)
            0, 1: addr.raw = {mem_pkg::REGION_WORK_RAM, 24'($urandom())};
            2, 3: addr.raw = {mem_pkg::REGION_PALETTE, 24'($urandom())};
            4: addr.raw = {mem_pkg::REGION_IO, 22'(mem_pkg::KEYINPUT_IDX), low};
            5: addr.raw = {mem_pkg::REGION_IO, 22'(mem_pkg::IF_IDX), low};
            6: addr.raw = {mem_pkg::REGION_IO, 22'(mem_pkg::FIFO_A_IDX), low};
            default: begin
                region = 8'($urandom());
                if (region >= 8'h03 && region <= 8'h05) begin
                    region = region + 8'h10;
                end
                addr.raw = {region, 24'($urandom())};
            end
        endcase
        return addr;
    endfunction

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, got %h at %0t",
                     name, expected, got, $time);
        end
    endtask

    // Sound FIFO effect of one clock edge
    task automatic apply_fifo(input logic push, input mem_pkg::word_t data,
                              input logic pop, input logic clr);
        logic can_push;
        logic can_pop;
        can_push = push && (fifo_model.size() < FIFO_DEPTH);
        can_pop  = pop && (fifo_model.size() > 0);
        if (clr) begin
            fifo_model.delete();
        end else begin
            if (can_pop) begin
                fifo_model.delete(0);
            end
            if (can_push) begin
                fifo_model.push_back(data);
            end
        end
    endtask

    task automatic model_write(input mem_pkg::bus_addr_t addr, input mem_pkg::mem_size_t size,
                               input mem_pkg::word_t data, input logic pop);
        logic [23:0]    off;
        logic [3:0]     lanes;
        int             idx;
        logic           push;
        mem_pkg::word_t acks_word;
        off   = addr.split.offset;
        lanes = lane_mask(size, addr.raw[1:0]);
        idx   = int'(off >> 2);
        push  = 1'b0;
        case (addr.split.region)
            mem_pkg::REGION_WORK_RAM: begin
                ram_model[idx % WORK_RAM_WORDS] =
                    merge_lanes(ram_model[idx % WORK_RAM_WORDS], data, lanes);
            end
            mem_pkg::REGION_PALETTE: begin
                pal_model[pal_bank(off)][pal_index(off)] =
                    merge_lanes(pal_model[pal_bank(off)][pal_index(off)], data, lanes);
            end
            mem_pkg::REGION_IO: begin
                if (idx == mem_pkg::KEYINPUT_IDX) begin
                    io_model[idx] = merge_lanes(io_model[idx], data, lanes & 4'b1100);
                end else if (idx == mem_pkg::IF_IDX) begin
                    io_model[idx] = merge_lanes(io_model[idx], data, lanes & 4'b0011);
                    acks_word     = merge_lanes('0, data, lanes & 4'b1100);
                    acks_expected = acks_word[31:16];
                end else if (idx == mem_pkg::FIFO_A_IDX) begin
                    push = lanes[0];
                end else if (idx < NUM_IO_REGS) begin
                    io_model[idx] = merge_lanes(io_model[idx], data, lanes);
                end
            end
            default: begin
            end
        endcase
        apply_fifo(push, data, pop, 1'b0);
    endtask

    // Falling edge, then the outputs that are visible every cycle
    task automatic next_cycle();
        @(negedge clock);
        check_word("int_acks", 32'(int_acks), 32'(acks_expected));
        check_word("ie", 32'(ie), 32'(io_model[mem_pkg::IF_IDX][15:0]));
        check_word("fifo_level", 32'(fifo_level), 32'(fifo_model.size()));
        if (fifo_model.size() > 0) begin
            check_word("fifo_sample", fifo_sample, fifo_model[0]);
        end
    endtask

    task automatic drive_side();
        buttons      = 16'($urandom());
        reg_if       = 16'($urandom());
        pal_bg_addr  = PAL_W'($urandom());
        pal_obj_addr = PAL_W'($urandom());
        fifo_pop     = strobes_on && ($urandom() % 12 == 0);
        fifo_clr     = strobes_on && ($urandom() % 150 == 0);
        bg_expected  = pal_model[0][pal_bg_addr];
        obj_expected = pal_model[1][pal_obj_addr];
    endtask

    task automatic check_graphics();
        check_word("pal_bg_data", pal_bg_data, bg_expected);
        check_word("pal_obj_data", pal_obj_data, obj_expected);
    endtask

    task automatic bus_read_op(input mem_pkg::bus_addr_t addr, input mem_pkg::mem_size_t size);
        mem_pkg::word_t expected;
        bus_addr  = addr;
        bus_size  = size;
        bus_write = 1'b0;
        drive_side();
        // FIFO head is sampled before this cycle's pop or clear
        expected = model_read(addr);
        apply_fifo(1'b0, '0, fifo_pop, fifo_clr);
        acks_expected = '0;
        next_cycle();
        check_graphics();
        check_word("bus_pause", 32'(bus_pause), 32'd0);
        check_word("bus_rdata", bus_rdata, expected);
    endtask

    task automatic bus_write_op(input mem_pkg::bus_addr_t addr, input mem_pkg::mem_size_t size);
        mem_pkg::word_t data;
        logic           pop;
        bus_addr  = addr;
        bus_size  = size;
        bus_write = 1'b1;
        bus_wdata = $urandom();
        drive_side();
        apply_fifo(1'b0, '0, fifo_pop, fifo_clr);
        acks_expected = '0;
        next_cycle();
        check_graphics();
        check_word("bus_pause", 32'(bus_pause), 32'd1);
        // Data phase while the master is paused
        data      = $urandom();
        pop       = strobes_on && ($urandom() % 12 == 0);
        bus_wdata = data;
        fifo_pop  = pop;
        fifo_clr  = 1'b0;
        model_write(addr, size, data, pop);
        next_cycle();
        check_word("bus_pause", 32'(bus_pause), 32'd0);
    endtask

    initial begin
        mem_pkg::bus_addr_t addr;
        mem_pkg::mem_size_t size;
        error_count   = 0;
        check_count   = 0;
        acks_expected = '0;
        strobes_on    = 1'b1;
        void'($urandom(32'h4dedd069));
        for (int i = 0; i < WORK_RAM_WORDS; i++) begin
            ram_model[i] = '0;
        end
        for (int i = 0; i < PALETTE_WORDS; i++) begin
            pal_model[0][i] = '0;
            pal_model[1][i] = '0;
        end
        for (int i = 0; i < NUM_IO_REGS; i++) begin
            io_model[i] = '0;
        end
        sweep = '{32'h0300_0010, 32'h0500_0004, 32'h0500_0204, 32'h0400_0030,
                  32'h0400_0200, 32'h0400_00a0, 32'h0900_0000};

        reset        = 1'b1;
        bus_addr     = '0;
        bus_size     = mem_pkg::SIZE_BYTE;
        bus_write    = 1'b0;
        bus_wdata    = '0;
        pal_bg_addr  = '0;
        pal_obj_addr = '0;
        buttons      = '0;
        reg_if       = '0;
        fifo_pop     = 1'b0;
        fifo_clr     = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        check_word("bus_pause", 32'(bus_pause), 32'd0);

        // Every region reads zero out of reset
        for (int i = 0; i < 7; i++) begin
            bus_addr = sweep[i];
            next_cycle();
            check_word("bus_rdata", bus_rdata, '0);
        end

        for (int op = 0; op < NUM_OPS; op++) begin
            addr = random_addr();
            size = mem_pkg::mem_size_t'($urandom() % 3);
            if ($urandom() % 2 == 0) begin
                bus_write_op(addr, size);
            end else begin
                if (addr.split.region == mem_pkg::REGION_IO &&
                    addr.split.offset[23:2] == 22'(mem_pkg::FIFO_A_IDX) &&
                    fifo_model.size() == 0) begin
                    addr.raw = {mem_pkg::REGION_IO, 22'(mem_pkg::KEYINPUT_IDX), 2'b00};
                end
                bus_read_op(addr, size);
            end
        end

        // Overfill the FIFO, read its head, then clear it
        strobes_on = 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            addr.raw = {mem_pkg::REGION_IO, 22'(mem_pkg::FIFO_A_IDX), 2'b00};
            bus_write_op(addr, mem_pkg::SIZE_WORD);
        end
        bus_read_op(addr, mem_pkg::SIZE_WORD);
        fifo_clr = 1'b1;
        apply_fifo(1'b0, '0, 1'b0, 1'b1);
        next_cycle();
        fifo_clr = 1'b0;
        next_cycle();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
